// ==== hdl/ex_stage_defs.svh ====
// Width macros for the execute stage
// Data path, register address, operation payload and shift amount
`ifndef EX_STAGE_DEFS_SVH
`define EX_STAGE_DEFS_SVH

//////////////////////////////
// Data path
//////////////////////////////

// Integer register width, RV32
`define EX_XLEN 32

// Register file address, 32 integer plus 32 extra entries
`define EX_RADDR_W 6

//////////////////////////////
// Operation encoding
//////////////////////////////

// Payload bits that ride along with the unit code
`define EX_OP_W 4

// Shift amount taken from the low bits of operand B
`define EX_SHAMT_W 5

`endif

// ==== hdl/ex_stage_pkg.sv ====
// Types of the execute stage
// Unit, ALU and multiply enums, ALU control struct
// Operation word with its payload union, write port structs
`include "ex_stage_defs.svh"

package ex_stage_pkg;

  // Unit that handles the operation
  typedef enum logic [1:0] {
    UNIT_NONE = 2'b00,
    UNIT_ALU  = 2'b01,
    UNIT_MULT = 2'b10,
    UNIT_CSR  = 2'b11
  } ex_unit_e;

  // ALU operations, compares last
  typedef enum logic [`EX_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    MULT_MUL,
    MULT_MULH,
    MULT_MULHSU,
    MULT_MULHU
  } mult_kind_e;

  // acc adds C, neg gives C minus the product
  typedef struct packed {
    mult_kind_e kind;
    logic       acc;
    logic       neg;
  } mult_op_t;

  // Same payload bits, decoded per unit
  typedef union packed {
    alu_op_e  alu;
    mult_op_t mult;
  } ex_op_u;

  typedef struct packed {
    ex_unit_e unit;
    ex_op_u   payload;
  } ex_op_t;

  // cmp_kind is the compare kind when comparing, else the logic function
  typedef struct packed {
    logic       invert_b;
    logic       shift_right;
    logic       shift_arith;
    logic       cmp_signed;
    logic [1:0] cmp_kind;
    logic       res_sel;
  } alu_ctrl_t;

  // ALU write port toward RF and ID
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } ex_fwd_t;

  // LSU write port toward WB
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } ex_wb_t;

endpackage

// ==== hdl/ex_op_decode.sv ====
// Operation decode for the execute stage
// Unit enables, ALU control bits and multiply op from the op word
module ex_op_decode (
  input  ex_stage_pkg::ex_op_t    op_i,
  input  logic                    enable_i,
  output ex_stage_pkg::ex_unit_e  unit_o,
  output logic                    alu_en_o,
  output logic                    mult_en_o,
  output logic                    csr_en_o,
  output ex_stage_pkg::alu_ctrl_t alu_ctrl_o,
  output ex_stage_pkg::mult_op_t  mult_op_o
);

  ex_stage_pkg::alu_op_e alu_op;

  // Unit code, forced to none when ID has nothing for us
  assign unit_o    = enable_i ? op_i.unit : ex_stage_pkg::UNIT_NONE;
  assign alu_en_o  = (unit_o == ex_stage_pkg::UNIT_ALU);
  assign mult_en_o = (unit_o == ex_stage_pkg::UNIT_MULT);
  assign csr_en_o  = (unit_o == ex_stage_pkg::UNIT_CSR);

  // Payload seen as ALU op
  assign alu_op = op_i.payload.alu;

  // Payload seen as multiply op, zero while the multiplier is idle
  assign mult_op_o = mult_en_o ? op_i.payload.mult : '0;

  //////////////////////////////
  // ALU control
  //////////////////////////////

  // res_sel clear: adder or logic, cmp_kind 00 add, 01 xor, 10 or, 11 and
  // res_sel set: shift when invert_b clear, compare when set
  // Compare kinds: 00 lt, 01 ge, 10 eq, 11 ne
  always_comb begin
    alu_ctrl_o = '0;
    case (alu_op)
      ex_stage_pkg::ALU_SUB: alu_ctrl_o.invert_b = 1'b1;
      ex_stage_pkg::ALU_XOR: alu_ctrl_o.cmp_kind = 2'b01;
      ex_stage_pkg::ALU_OR:  alu_ctrl_o.cmp_kind = 2'b10;
      ex_stage_pkg::ALU_AND: alu_ctrl_o.cmp_kind = 2'b11;
      ex_stage_pkg::ALU_SLL: alu_ctrl_o.res_sel = 1'b1;
      ex_stage_pkg::ALU_SRL: begin
        alu_ctrl_o.res_sel     = 1'b1;
        alu_ctrl_o.shift_right = 1'b1;
      end
      ex_stage_pkg::ALU_SRA: begin
        alu_ctrl_o.res_sel     = 1'b1;
        alu_ctrl_o.shift_right = 1'b1;
        alu_ctrl_o.shift_arith = 1'b1;
      end
      ex_stage_pkg::ALU_SLT, ex_stage_pkg::ALU_LT, ex_stage_pkg::ALU_GE: begin
        alu_ctrl_o.res_sel    = 1'b1;
        alu_ctrl_o.invert_b   = 1'b1;
        alu_ctrl_o.cmp_signed = 1'b1;
        alu_ctrl_o.cmp_kind   = (alu_op == ex_stage_pkg::ALU_GE) ? 2'b01 : 2'b00;
      end
      ex_stage_pkg::ALU_SLTU, ex_stage_pkg::ALU_LTU, ex_stage_pkg::ALU_GEU: begin
        alu_ctrl_o.res_sel  = 1'b1;
        alu_ctrl_o.invert_b = 1'b1;
        alu_ctrl_o.cmp_kind = (alu_op == ex_stage_pkg::ALU_GEU) ? 2'b01 : 2'b00;
      end
      ex_stage_pkg::ALU_EQ, ex_stage_pkg::ALU_NE: begin
        alu_ctrl_o.res_sel  = 1'b1;
        alu_ctrl_o.invert_b = 1'b1;
        alu_ctrl_o.cmp_kind = (alu_op == ex_stage_pkg::ALU_NE) ? 2'b11 : 2'b10;
      end
      // Add keeps all controls clear
      default: alu_ctrl_o = '0;
    endcase
  end

endmodule

// ==== hdl/ex_alu.sv ====
// Integer ALU of the execute stage
// Shared adder, logic functions, barrel shifter, comparator
// Compare bit drives the branch decision
`include "ex_stage_defs.svh"

module ex_alu (
  input  logic                    enable_i,
  input  ex_stage_pkg::alu_ctrl_t ctrl_i,
  input  logic [`EX_XLEN-1:0]     operand_a_i,
  input  logic [`EX_XLEN-1:0]     operand_b_i,
  output logic [`EX_XLEN-1:0]     result_o,
  output logic                    cmp_result_o
);

  logic [`EX_XLEN-1:0]      b_eff;
  logic [`EX_XLEN:0]        add_full;
  logic [`EX_XLEN-1:0]      add_res;
  logic                     add_carry;
  logic [`EX_XLEN-1:0]      logic_res;
  logic [`EX_SHAMT_W-1:0]   shamt;
  logic signed [`EX_XLEN:0] shr_in;
  logic signed [`EX_XLEN:0] shr_full;
  logic [`EX_XLEN-1:0]      shift_res;
  logic                     is_cmp;
  logic                     is_shift;
  logic                     lt;
  logic                     eq;
  logic                     cmp_bit;
  logic [`EX_XLEN-1:0]      alu_res;

  assign is_cmp   = ctrl_i.res_sel & ctrl_i.invert_b;
  assign is_shift = ctrl_i.res_sel & ~ctrl_i.invert_b;

  //////////////////////////////
  // Adder
  //////////////////////////////

  // Subtract as A + ~B + 1, carry out kept for unsigned compare
  assign b_eff    = ctrl_i.invert_b ? ~operand_b_i : operand_b_i;
  assign add_full = {1'b0, operand_a_i} + {1'b0, b_eff} + {{`EX_XLEN{1'b0}}, ctrl_i.invert_b};
  assign add_res   = add_full[`EX_XLEN-1:0];
  assign add_carry = add_full[`EX_XLEN];

  // Logic functions share the adder's output mux
  always_comb begin
    case (ctrl_i.cmp_kind)
      2'b01:   logic_res = operand_a_i ^ operand_b_i;
      2'b10:   logic_res = operand_a_i | operand_b_i;
      2'b11:   logic_res = operand_a_i & operand_b_i;
      default: logic_res = add_res;
    endcase
  end

  //////////////////////////////
  // Shifter
  //////////////////////////////

  assign shamt = operand_b_i[`EX_SHAMT_W-1:0];

  // Extra top bit carries the fill, sign for sra and zero for srl
  assign shr_in   = {ctrl_i.shift_arith & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign shr_full = shr_in >>> shamt;

  assign shift_res = ctrl_i.shift_right ? shr_full[`EX_XLEN-1:0] : (operand_a_i << shamt);

  //////////////////////////////
  // Comparator
  //////////////////////////////

  // Signed: if signs differ A is less when negative, else sign of A - B
  // Unsigned: A below B exactly when A - B borrows
  always_comb begin
    if (ctrl_i.cmp_signed) begin
      if (operand_a_i[`EX_XLEN-1] != operand_b_i[`EX_XLEN-1]) begin
        lt = operand_a_i[`EX_XLEN-1];
      end else begin
        lt = add_res[`EX_XLEN-1];
      end
    end else begin
      lt = ~add_carry;
    end
  end

  // Zero detect on the XOR of the operands
  assign eq = ~|(operand_a_i ^ operand_b_i);

  always_comb begin
    case (ctrl_i.cmp_kind)
      2'b00:   cmp_bit = lt;
      2'b01:   cmp_bit = ~lt;
      2'b10:   cmp_bit = eq;
      default: cmp_bit = ~eq;
    endcase
  end

  // Result select, set ops give the compare bit zero extended
  always_comb begin
    if (is_cmp) begin
      alu_res = {{(`EX_XLEN-1){1'b0}}, cmp_bit};
    end else if (is_shift) begin
      alu_res = shift_res;
    end else begin
      alu_res = logic_res;
    end
  end

  // Outputs quiet while the ALU is not selected
  assign result_o     = enable_i ? alu_res : '0;
  assign cmp_result_o = enable_i & is_cmp & cmp_bit;

endmodule

// ==== hdl/ex_mult.sv ====
// Multiplier of the execute stage
// Single cycle MUL, MAC and MSU on the low product
// Two cycle MULH, MULHSU and MULHU through a registered high half
`include "ex_stage_defs.svh"

module ex_mult (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable_i,
  input  ex_stage_pkg::mult_op_t op_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic [`EX_XLEN-1:0]    operand_c_i,
  input  logic                   ex_ready_i,
  output logic [`EX_XLEN-1:0]    result_o,
  output logic                   ready_o,
  output logic                   multicycle_o
);

  logic                         a_sign;
  logic                         b_sign;
  logic signed [`EX_XLEN:0]     a_ext;
  logic signed [`EX_XLEN:0]     b_ext;
  logic signed [2*`EX_XLEN+1:0] prod;
  logic [`EX_XLEN-1:0]          prod_lo;
  logic [`EX_XLEN-1:0]          prod_hi;
  logic [`EX_XLEN-1:0]          mac_res;
  logic                         is_high;
  logic                         high_q;
  logic [`EX_XLEN-1:0]          high_res_q;

  //////////////////////////////
  // Product
  //////////////////////////////

  // A signed unless mulhu, B signed only for mulh
  // Low half does not depend on the extension
  assign a_sign = (op_i.kind != ex_stage_pkg::MULT_MULHU) & operand_a_i[`EX_XLEN-1];
  assign b_sign = (op_i.kind == ex_stage_pkg::MULT_MULH) & operand_b_i[`EX_XLEN-1];
  assign a_ext  = {a_sign, operand_a_i};
  assign b_ext  = {b_sign, operand_b_i};

  // One 33x33 signed multiply serves every kind
  assign prod    = a_ext * b_ext;
  assign prod_lo = prod[`EX_XLEN-1:0];
  assign prod_hi = prod[2*`EX_XLEN-1:`EX_XLEN];

  // MSU gives C minus the product, MAC adds C
  always_comb begin
    if (op_i.neg) begin
      mac_res = operand_c_i - prod_lo;
    end else if (op_i.acc) begin
      mac_res = operand_c_i + prod_lo;
    end else begin
      mac_res = prod_lo;
    end
  end

  //////////////////////////////
  // High half path
  //////////////////////////////

  assign is_high = enable_i & (op_i.kind != ex_stage_pkg::MULT_MUL);

  // First cycle of a high multiply stalls the stage
  assign multicycle_o = is_high & ~high_q;
  assign ready_o      = ~multicycle_o;

  // State bit, set on the first cycle, cleared once the stage moves on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      high_q <= 1'b0;
    end else if (multicycle_o) begin
      high_q <= 1'b1;
    end else if (high_q && ex_ready_i) begin
      high_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      high_res_q <= prod_hi;
    end
  end

  // Held high result wins until accepted
  assign result_o = high_q ? high_res_q : mac_res;

endmodule

// ==== hdl/ex_writeback.sv ====
// Result side of the execute stage
// ALU write port mux, EX/WB register for loads, stage ready and valid
`include "ex_stage_defs.svh"

module ex_writeback (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ex_stage_pkg::ex_unit_e unit_i,
  input  logic [`EX_XLEN-1:0]    alu_result_i,
  input  logic [`EX_XLEN-1:0]    mult_result_i,
  input  logic                   mult_ready_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic [`EX_RADDR_W-1:0] fwd_waddr_i,
  input  logic                   fwd_we_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   rf_we_i,
  input  logic [`EX_RADDR_W-1:0] rf_waddr_i,
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,
  output ex_stage_pkg::ex_fwd_t  fwd_o,
  output ex_stage_pkg::ex_wb_t   wb_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic                   wb_we_q;
  logic [`EX_RADDR_W-1:0] wb_waddr_q;
  logic                   units_ready;
  logic                   active;

  // ALU write port, data picked by the unit in use
  always_comb begin
    fwd_o.we    = fwd_we_i;
    fwd_o.waddr = fwd_waddr_i;
    case (unit_i)
      ex_stage_pkg::UNIT_ALU:  fwd_o.wdata = alu_result_i;
      ex_stage_pkg::UNIT_MULT: fwd_o.wdata = mult_result_i;
      ex_stage_pkg::UNIT_CSR:  fwd_o.wdata = csr_rdata_i;
      default:                 fwd_o.wdata = '0;
    endcase
  end

  //////////////////////////////
  // Stall control
  //////////////////////////////

  // ALU is always ready, so only the multiplier, LSU and WB count
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign active      = (unit_i != ex_stage_pkg::UNIT_NONE) | lsu_en_i;

  // Branches resolve here without needing WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = active & units_ready;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // Valid implies WB ready; with nothing new and WB ready, drain the slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      wb_we_q <= rf_we_i;
    end else if (wb_ready_i) begin
      wb_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && rf_we_i) begin
      wb_waddr_q <= rf_waddr_i;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

// ==== hdl/ex_stage.sv ====
// Execute stage top level
// Decode, ALU, multiplier and result logic wired together
`include "ex_stage_defs.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // Operation and operands from ID
  input  ex_stage_pkg::ex_op_t   op_i,
  input  logic                   enable_i,
  input  logic [`EX_XLEN-1:0]    operand_a_i,
  input  logic [`EX_XLEN-1:0]    operand_b_i,
  input  logic [`EX_XLEN-1:0]    operand_c_i,
  input  logic [`EX_RADDR_W-1:0] fwd_waddr_i,
  input  logic                   fwd_we_i,
  // Load destination, passed on to WB
  input  logic                   rf_we_i,
  input  logic [`EX_RADDR_W-1:0] rf_waddr_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,
  // Write ports
  output ex_stage_pkg::ex_fwd_t  fwd_o,
  output ex_stage_pkg::ex_wb_t   wb_o,
  // Branch target and decision toward IF
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,
  output logic                   mult_multicycle_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  ex_stage_pkg::ex_unit_e  unit;
  ex_stage_pkg::alu_ctrl_t alu_ctrl;
  ex_stage_pkg::mult_op_t  mult_op;
  logic                    alu_en;
  logic                    mult_en;
  logic [`EX_XLEN-1:0]     alu_result;
  logic [`EX_XLEN-1:0]     mult_result;
  logic                    mult_ready;

  // Jump target is computed in ID and only passes through
  assign jump_target_o = operand_c_i;

  //////////////////////////////
  // Decode
  //////////////////////////////

  // CSR enable is carried in the unit code toward the result mux
  ex_op_decode i_decode (
    .op_i       (op_i),
    .enable_i   (enable_i),
    .unit_o     (unit),
    .alu_en_o   (alu_en),
    .mult_en_o  (mult_en),
    .csr_en_o   (),
    .alu_ctrl_o (alu_ctrl),
    .mult_op_o  (mult_op)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  ex_alu i_alu (
    .enable_i     (alu_en),
    .ctrl_i       (alu_ctrl),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en),
    .op_i         (mult_op),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .operand_c_i  (operand_c_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////
  // Result
  //////////////////////////////

  ex_writeback i_writeback (
    .clk            (clk),
    .rst_n          (rst_n),
    .unit_i         (unit),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .mult_ready_i   (mult_ready),
    .csr_rdata_i    (csr_rdata_i),
    .fwd_waddr_i    (fwd_waddr_i),
    .fwd_we_i       (fwd_we_i),
    .lsu_en_i       (lsu_en_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .branch_in_ex_i (branch_in_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fwd_o          (fwd_o),
    .wb_o           (wb_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

// ==== testbench/ex_stage_assert.sv ====
// Protocol assertions for the execute stage, bound to ex_stage
// Stall on high multiply, clean WB slot after reset, valid only with WB ready
module ex_stage_assert (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 multicycle_i,
  input logic                 ex_ready_i,
  input logic                 ex_valid_i,
  input logic                 wb_ready_i,
  input ex_stage_pkg::ex_wb_t wb_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read back by the testbench at the end
  int unsigned fail_count = 0;

  // First cycle of MULH kinds must hold the stage
  a_mult_stall: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_i |-> !ex_ready_i)
  else begin
    fail_count++;
    $error("Stage ready while the multiplier is in its first high cycle");
  end

  // EX/WB slot empty right after reset
  a_wb_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_i.we)
  else begin
    fail_count++;
    $error("Writeback enable set in the first cycle after reset");
  end

  a_valid_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
  else begin
    fail_count++;
    $error("Stage valid while writeback is not ready");
  end

endmodule

bind ex_stage ex_stage_assert i_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .multicycle_i (mult_multicycle_o),
  .ex_ready_i   (ex_ready_o),
  .ex_valid_i   (ex_valid_o),
  .wb_ready_i   (wb_ready_i),
  .wb_i         (wb_o)
);

// ==== testbench/ex_stage_tb.sv ====
// Testbench for the execute stage
// Stimulus table with reference results, applied row by row
// Stall, forward port, branch and EX/WB register checks, cycle limit
`include "ex_stage_defs.svh"

module ex_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // One table row with stimulus and the expected answer
  typedef struct {
    string                  name;
    ex_stage_pkg::ex_op_t   op;
    logic [`EX_XLEN-1:0]    a, b, c, csr;
    logic                   lsu_en, rf_we;
    logic [`EX_RADDR_W-1:0] rf_waddr;
    logic [`EX_XLEN-1:0]    lsu_rdata;
    logic                   wb_ready;
    logic [`EX_XLEN-1:0]    exp_wdata;
    logic                   exp_branch;
    int                     exp_stall;
    logic                   exp_wb_we;
    logic [`EX_RADDR_W-1:0] exp_wb_waddr;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  ex_stage_pkg::ex_op_t   op_i;
  logic                   enable_i;
  logic [`EX_XLEN-1:0]    operand_a_i, operand_b_i, operand_c_i;
  logic [`EX_RADDR_W-1:0] fwd_waddr_i, rf_waddr_i;
  logic                   fwd_we_i, rf_we_i;
  logic [`EX_XLEN-1:0]    csr_rdata_i, lsu_rdata_i;
  logic                   lsu_en_i, lsu_ready_ex_i, branch_in_ex_i, wb_ready_i;
  ex_stage_pkg::ex_fwd_t  fwd_o;
  ex_stage_pkg::ex_wb_t   wb_o;
  logic [`EX_XLEN-1:0]    jump_target_o;
  logic                   branch_decision_o, mult_multicycle_o, ex_ready_o, ex_valid_o;

  row_t rows[$];
  int   seed = 45773;
  int   cycle_count;
  int   cycle_limit;

  ex_stage i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .op_i              (op_i),
    .enable_i          (enable_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_c_i       (operand_c_i),
    .fwd_waddr_i       (fwd_waddr_i),
    .fwd_we_i          (fwd_we_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .csr_rdata_i       (csr_rdata_i),
    .lsu_en_i          (lsu_en_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .wb_ready_i        (wb_ready_i),
    .fwd_o             (fwd_o),
    .wb_o              (wb_o),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .mult_multicycle_o (mult_multicycle_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  always #5 clk = ~clk;

  // Run limit from reset length and table size
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the tests did not complete within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // RV32I integer semantics with compares giving 0 or 1
  function automatic logic [`EX_XLEN-1:0] alu_model(input ex_stage_pkg::alu_op_e op,
                                                    input logic [`EX_XLEN-1:0] a,
                                                    input logic [`EX_XLEN-1:0] b);
    logic [`EX_SHAMT_W-1:0] sh;
    sh = b[`EX_SHAMT_W-1:0];
    case (op)
      ex_stage_pkg::ALU_ADD:  return a + b;
      ex_stage_pkg::ALU_SUB:  return a - b;
      ex_stage_pkg::ALU_XOR:  return a ^ b;
      ex_stage_pkg::ALU_OR:   return a | b;
      ex_stage_pkg::ALU_AND:  return a & b;
      ex_stage_pkg::ALU_SLL:  return a << sh;
      ex_stage_pkg::ALU_SRL:  return a >> sh;
      ex_stage_pkg::ALU_SRA:  return $signed(a) >>> sh;
      ex_stage_pkg::ALU_SLT, ex_stage_pkg::ALU_LT: return ($signed(a) < $signed(b)) ? 1 : 0;
      ex_stage_pkg::ALU_SLTU, ex_stage_pkg::ALU_LTU: return (a < b) ? 1 : 0;
      ex_stage_pkg::ALU_EQ:   return (a == b) ? 1 : 0;
      ex_stage_pkg::ALU_NE:   return (a != b) ? 1 : 0;
      ex_stage_pkg::ALU_GE:   return ($signed(a) >= $signed(b)) ? 1 : 0;
      default:                return (a >= b) ? 1 : 0;
    endcase
  endfunction

  // Full 64 bit product with RISC-V M operand signedness
  function automatic logic [`EX_XLEN-1:0] mult_model(input ex_stage_pkg::mult_kind_e kind,
                                                     input logic acc, input logic neg,
                                                     input logic [`EX_XLEN-1:0] a,
                                                     input logic [`EX_XLEN-1:0] b,
                                                     input logic [`EX_XLEN-1:0] c);
    logic signed [2*`EX_XLEN-1:0] sa;
    logic signed [2*`EX_XLEN-1:0] sb;
    logic [2*`EX_XLEN-1:0]        p;
    logic [`EX_XLEN-1:0]          lo;
    sa = (kind == ex_stage_pkg::MULT_MULHU) ? {{`EX_XLEN{1'b0}}, a} :
                                              {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
    sb = (kind == ex_stage_pkg::MULT_MULH) ? {{`EX_XLEN{b[`EX_XLEN-1]}}, b} :
                                             {{`EX_XLEN{1'b0}}, b};
    p  = sa * sb;
    lo = p[`EX_XLEN-1:0];
    if (kind != ex_stage_pkg::MULT_MUL) return p[2*`EX_XLEN-1:`EX_XLEN];
    if (neg) return c - lo;
    if (acc) return c + lo;
    return lo;
  endfunction

  //////////////////////////////
  // Table building
  //////////////////////////////

  // Idle row with WB ready and nothing expected
  function automatic row_t blank_row(input string name);
    row_t r;
    r.name         = name;
    r.op           = '0;
    r.a            = '0;
    r.b            = '0;
    r.c            = '0;
    r.csr          = '0;
    r.lsu_en       = 1'b0;
    r.rf_we        = 1'b0;
    r.rf_waddr     = '0;
    r.lsu_rdata    = '0;
    r.wb_ready     = 1'b1;
    r.exp_wdata    = '0;
    r.exp_branch   = 1'b0;
    r.exp_stall    = 0;
    r.exp_wb_we    = 1'b0;
    r.exp_wb_waddr = '0;
    return r;
  endfunction

  task automatic alu_row(input string name, input ex_stage_pkg::alu_op_e op,
                         input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    row_t r;
    r = blank_row(name);
    r.op.unit        = ex_stage_pkg::UNIT_ALU;
    r.op.payload.alu = op;
    r.a              = a;
    r.b              = b;
    // Jump target only passes through and may be any value
    r.c              = a ^ b;
    r.exp_wdata      = alu_model(op, a, b);
    // Set and branch compares drive the decision
    r.exp_branch     = (op >= ex_stage_pkg::ALU_SLT) & r.exp_wdata[0];
    rows.push_back(r);
  endtask

  task automatic mult_row(input string name, input ex_stage_pkg::mult_kind_e kind,
                          input logic acc, input logic neg, input logic [`EX_XLEN-1:0] a,
                          input logic [`EX_XLEN-1:0] b, input logic [`EX_XLEN-1:0] c);
    row_t                   r;
    ex_stage_pkg::mult_op_t m;
    m.kind = kind;
    m.acc  = acc;
    m.neg  = neg;
    r = blank_row(name);
    r.op.unit         = ex_stage_pkg::UNIT_MULT;
    r.op.payload.mult = m;
    r.a               = a;
    r.b               = b;
    r.c               = c;
    r.exp_wdata       = mult_model(kind, acc, neg, a, b, c);
    // High half costs one extra cycle
    r.exp_stall       = (kind != ex_stage_pkg::MULT_MUL) ? 1 : 0;
    rows.push_back(r);
  endtask

  task automatic csr_row(input string name, input logic [`EX_XLEN-1:0] data);
    row_t r;
    r = blank_row(name);
    r.op.unit   = ex_stage_pkg::UNIT_CSR;
    r.csr       = data;
    r.exp_wdata = data;
    rows.push_back(r);
  endtask

  task automatic load_row(input string name, input logic [`EX_RADDR_W-1:0] waddr,
                          input logic [`EX_XLEN-1:0] rdata, input logic wb_ready,
                          input logic exp_we, input logic [`EX_RADDR_W-1:0] exp_waddr);
    row_t r;
    r = blank_row(name);
    r.lsu_en       = 1'b1;
    r.rf_we        = 1'b1;
    r.rf_waddr     = waddr;
    r.lsu_rdata    = rdata;
    r.wb_ready     = wb_ready;
    r.exp_wb_we    = exp_we;
    r.exp_wb_waddr = exp_waddr;
    rows.push_back(r);
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic drive_row(input row_t r, input int idx);
    op_i           = r.op;
    enable_i       = (r.op.unit != ex_stage_pkg::UNIT_NONE);
    operand_a_i    = r.a;
    operand_b_i    = r.b;
    operand_c_i    = r.c;
    fwd_we_i       = (r.op.unit != ex_stage_pkg::UNIT_NONE);
    fwd_waddr_i    = idx[`EX_RADDR_W-1:0];
    rf_we_i        = r.rf_we;
    rf_waddr_i     = r.rf_waddr;
    csr_rdata_i    = r.csr;
    lsu_en_i       = r.lsu_en;
    lsu_rdata_i    = r.lsu_rdata;
    lsu_ready_ex_i = 1'b1;
    branch_in_ex_i = 1'b0;
    wb_ready_i     = r.wb_ready;
  endtask

  task automatic check_value(input string name, input logic [`EX_XLEN-1:0] expected,
                             input logic [`EX_XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  initial begin
    row_t                  r;
    int                    stalls;
    logic [`EX_XLEN-1:0]   d;
    ex_stage_pkg::alu_op_e op;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cycle_count = 0;
    cycle_limit = 0;
    drive_row(blank_row("idle"), 0);

    // Every ALU op with fixed, random and equal operands
    for (int k = 0; k < 16; k++) begin
      op = ex_stage_pkg::alu_op_e'(k);
      alu_row($sformatf("%s fixed", op.name()), op, 32'h8000_0010, 32'h0000_0023);
      alu_row($sformatf("%s random", op.name()), op, $random(seed), $random(seed));
      d = $random(seed);
      alu_row($sformatf("%s equal", op.name()), op, d, d);
    end
    mult_row("mul fixed", ex_stage_pkg::MULT_MUL, 0, 0, 32'h7, 32'hFFFF_FFFD, 32'h0);
    mult_row("mac fixed", ex_stage_pkg::MULT_MUL, 1, 0, 32'h7, 32'hFFFF_FFFD, 32'h100);
    mult_row("msu fixed", ex_stage_pkg::MULT_MUL, 0, 1, 32'h7, 32'hFFFF_FFFD, 32'h100);
    mult_row("mulh fixed", ex_stage_pkg::MULT_MULH, 0, 0, 32'h8000_0000, 32'h8000_0000, 0);
    mult_row("mulhsu fixed", ex_stage_pkg::MULT_MULHSU, 0, 0, '1, '1, 0);
    mult_row("mulhu fixed", ex_stage_pkg::MULT_MULHU, 0, 0, '1, '1, 0);
    for (int k = 0; k < 4; k++) begin
      mult_row("mul random", ex_stage_pkg::MULT_MUL, 0, 0, $random(seed), $random(seed), 0);
      mult_row("mac random", ex_stage_pkg::MULT_MUL, 1, 0, $random(seed), $random(seed),
               $random(seed));
      mult_row("msu random", ex_stage_pkg::MULT_MUL, 0, 1, $random(seed), $random(seed),
               $random(seed));
      mult_row("mulh random", ex_stage_pkg::MULT_MULH, 0, 0, $random(seed), $random(seed), 0);
      mult_row("mulhsu random", ex_stage_pkg::MULT_MULHSU, 0, 0, $random(seed),
               $random(seed), 0);
      mult_row("mulhu random", ex_stage_pkg::MULT_MULHU, 0, 0, $random(seed), $random(seed), 0);
    end
    csr_row("csr fixed", 32'hC0DE_0001);
    csr_row("csr random", $random(seed));
    // Load, stall on WB, release, then drain the slot
    load_row("load", 6'd5, $random(seed), 1'b1, 1'b1, 6'd5);
    d = $random(seed);
    load_row("load held", 6'd9, d, 1'b0, 1'b1, 6'd5);
    load_row("load released", 6'd9, d, 1'b1, 1'b1, 6'd9);
    rows.push_back(blank_row("drain"));
    cycle_limit = 16 + 3 * rows.size() + 20;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    foreach (rows[i]) begin
      r = rows[i];
      drive_row(r, i);
      #1;
      stalls = 0;
      if (r.wb_ready) begin
        while (!ex_ready_o) begin
          // A stall cycle is the first cycle of a high multiply
          check_value({r.name, " multicycle"}, 1, mult_multicycle_o);
          @(negedge clk);
          #1;
          stalls++;
        end
        check_value({r.name, " stall cycles"}, r.exp_stall, stalls);
        check_value({r.name, " multicycle"}, 0, mult_multicycle_o);
        check_value({r.name, " valid"}, enable_i | lsu_en_i, ex_valid_o);
        check_value({r.name, " fwd we"}, fwd_we_i, fwd_o.we);
        check_value({r.name, " fwd waddr"}, fwd_waddr_i, fwd_o.waddr);
        if (fwd_we_i) begin
          check_value({r.name, " fwd wdata"}, r.exp_wdata, fwd_o.wdata);
        end
        check_value({r.name, " branch"}, r.exp_branch, branch_decision_o);
        check_value({r.name, " jump target"}, r.c, jump_target_o);
      end else begin
        // Back-pressure holds the whole stage
        check_value({r.name, " ready"}, 0, ex_ready_o);
        check_value({r.name, " valid"}, 0, ex_valid_o);
        check_value({r.name, " multicycle"}, 0, mult_multicycle_o);
      end
      @(negedge clk);
      check_value({r.name, " wb we"}, r.exp_wb_we, wb_o.we);
      if (r.exp_wb_we) begin
        check_value({r.name, " wb waddr"}, r.exp_wb_waddr, wb_o.waddr);
        check_value({r.name, " wb wdata"}, r.lsu_rdata, wb_o.wdata);
      end
    end

    if (i_dut.i_assert.fail_count != 0) begin
      $display("Bound protocol assertions failed %0d times", i_dut.i_assert.fail_count);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped on assertion failures");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== ex_stage.f ====
+incdir+hdl
hdl/ex_stage_pkg.sv
hdl/ex_op_decode.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
testbench/ex_stage_assert.sv
testbench/ex_stage_tb.sv
